//--- rtl/descent_pkg.sv
package descent_pkg;

    ////////////////////////////////////////////////////////////
    // vector size and fixed-point format
    ////////////////////////////////////////////////////////////

    localparam int N_ELEM    = 8;
    localparam int FRAC_BITS = 16;

    localparam int VAL_W   = 32;
    localparam int OBJ_W   = 48;
    localparam int ADDR_W  = 3;
    localparam int SHIFT_W = 4;
    localparam int ITER_W  = 5;

    // Q16.16 element, weight, mean and gradient
    typedef logic signed [VAL_W-1:0] val_t;
    // Q32.16 objective
    typedef logic signed [OBJ_W-1:0] obj_t;
    typedef logic [ADDR_W-1:0]       addr_t;
    // step is 2**-k
    typedef logic [SHIFT_W-1:0]      shift_t;
    typedef logic [ITER_W-1:0]       iter_t;

    ////////////////////////////////////////////////////////////
    // tuning
    ////////////////////////////////////////////////////////////

    localparam int MAX_SHIFT = 12;
    localparam int MAX_ITER  = 16;

    // 2**-10 in Q32.16
    localparam obj_t EPSILON = obj_t'(1) <<< (FRAC_BITS - 10);

    ////////////////////////////////////////////////////////////
    // state encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_INIT_EVAL,
        PH_SEARCH,
        PH_JUDGE,
        PH_DONE
    } phase_t;

    typedef enum logic [1:0] {
        LS_IDLE,
        LS_STEP,
        LS_EVAL,
        LS_DECIDE
    } ls_state_t;

endpackage

//--- rtl/objective_eval.sv
module objective_eval (
    input  logic               clk,
    input  logic               rst_LBFGS,
    input  logic               param_we,
    input  descent_pkg::addr_t param_addr,
    input  descent_pkg::val_t  param_weight,
    input  descent_pkg::val_t  param_mean,
    input  logic               eval_start,
    input  descent_pkg::val_t  eval_point [descent_pkg::N_ELEM],
    output logic               eval_done,
    output descent_pkg::obj_t  eval_f,
    output descent_pkg::val_t  eval_grad [descent_pkg::N_ELEM]
);

    descent_pkg::val_t weight_mem [descent_pkg::N_ELEM];
    descent_pkg::val_t mean_mem   [descent_pkg::N_ELEM];

    // element walk
    logic               run;
    descent_pkg::addr_t idx;

    // stage 1 results, distance and weighted distance
    logic               s1_valid;
    logic               s1_last;
    descent_pkg::val_t  s1_d;
    logic signed [63:0] s1_p;

    descent_pkg::val_t  d_cur;
    logic signed [63:0] wd_full;
    logic signed [95:0] sq_full;
    logic signed [95:0] term_full;
    logic signed [63:0] grad_full;
    descent_pkg::obj_t  term;
    descent_pkg::val_t  grad_elem;

    always_ff @(posedge clk) begin
        if (param_we) begin
            weight_mem[param_addr] <= param_weight;
            mean_mem[param_addr]   <= param_mean;
        end
    end

    always_comb begin
        d_cur     = eval_point[idx] - mean_mem[idx];
        wd_full   = weight_mem[idx] * d_cur;
        sq_full   = s1_p * s1_d;
        term_full = sq_full >>> descent_pkg::FRAC_BITS;
        term      = descent_pkg::obj_t'(term_full);
        // gradient element is 2*w*d
        grad_full = s1_p <<< 1;
        grad_elem = descent_pkg::val_t'(grad_full);
    end

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            run       <= 1'b0;
            idx       <= '0;
            s1_valid  <= 1'b0;
            s1_last   <= 1'b0;
            eval_done <= 1'b0;
        end else begin
            s1_valid  <= run;
            s1_last   <= run && (idx == descent_pkg::N_ELEM - 1);
            eval_done <= s1_valid && s1_last;
            if (eval_start) begin
                run <= 1'b1;
                idx <= '0;
            end else if (run) begin
                idx <= idx + 3'd1;
                if (idx == descent_pkg::N_ELEM - 1) begin
                    run <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (run) begin
            s1_d <= d_cur;
            s1_p <= wd_full >>> descent_pkg::FRAC_BITS;
        end
        if (eval_start) begin
            eval_f <= '0;
        end else if (s1_valid) begin
            eval_f <= eval_f + term;
            // gradient enters at the top and walks down to its index
            for (int i = 0; i < descent_pkg::N_ELEM - 1; i++) begin
                eval_grad[i] <= eval_grad[i+1];
            end
            eval_grad[descent_pkg::N_ELEM-1] <= grad_elem;
        end
    end

    // controller waits for eval_done before the next point
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        eval_start |-> !(run || s1_valid));

endmodule

//--- rtl/point_update.sv
module point_update (
    input  logic                clk,
    input  logic                rst_LBFGS,
    input  logic                step_start,
    input  descent_pkg::shift_t step_shift,
    input  descent_pkg::val_t   base_point [descent_pkg::N_ELEM],
    input  descent_pkg::val_t   grad       [descent_pkg::N_ELEM],
    output logic                step_done,
    output descent_pkg::val_t   trial_point [descent_pkg::N_ELEM]
);

    logic                run;
    descent_pkg::addr_t  idx;
    descent_pkg::shift_t k;
    descent_pkg::val_t   scaled;

    // step of 2**-k on the negative gradient
    always_comb begin
        scaled = grad[idx] >>> k;
    end

    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            run       <= 1'b0;
            idx       <= '0;
            step_done <= 1'b0;
        end else begin
            step_done <= run && (idx == descent_pkg::N_ELEM - 1);
            if (step_start) begin
                run <= 1'b1;
                idx <= '0;
            end else if (run) begin
                idx <= idx + 3'd1;
                if (idx == descent_pkg::N_ELEM - 1) begin
                    run <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step_start) begin
            k <= step_shift;
        end
        if (run) begin
            trial_point[idx] <= base_point[idx] - scaled;
        end
    end

    // line search stops at MAX_SHIFT
    a_shift_range: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        step_start |-> (step_shift <= descent_pkg::MAX_SHIFT));

endmodule

//--- rtl/line_search.sv
module line_search (
    input  logic                clk,
    input  logic                rst_LBFGS,
    input  logic                ls_start,
    input  descent_pkg::obj_t   f_now,
    input  descent_pkg::obj_t   eval_f,
    input  logic                ls_eval_done,
    input  logic                step_done,
    output logic                step_start,
    output descent_pkg::shift_t step_shift,
    output logic                ls_eval_req,
    output logic                ls_done,
    output logic                ls_ok
);

    descent_pkg::ls_state_t state;
    descent_pkg::shift_t    k;

    assign step_shift = k;

    ////////////////////////////////////////////////////////////
    // backtracking over k = 0 .. MAX_SHIFT
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            state       <= descent_pkg::LS_IDLE;
            k           <= '0;
            step_start  <= 1'b0;
            ls_eval_req <= 1'b0;
            ls_done     <= 1'b0;
            ls_ok       <= 1'b0;
        end else begin
            step_start  <= 1'b0;
            ls_eval_req <= 1'b0;
            ls_done     <= 1'b0;
            case (state)
                descent_pkg::LS_IDLE: begin
                    if (ls_start) begin
                        k          <= '0;
                        ls_ok      <= 1'b0;
                        step_start <= 1'b1;
                        state      <= descent_pkg::LS_STEP;
                    end
                end
                descent_pkg::LS_STEP: begin
                    // trial point ready, have it evaluated
                    if (step_done) begin
                        ls_eval_req <= 1'b1;
                        state       <= descent_pkg::LS_EVAL;
                    end
                end
                descent_pkg::LS_EVAL: begin
                    if (ls_eval_done) begin
                        state <= descent_pkg::LS_DECIDE;
                    end
                end
                descent_pkg::LS_DECIDE: begin
                    if (eval_f < f_now) begin
                        ls_ok   <= 1'b1;
                        ls_done <= 1'b1;
                        state   <= descent_pkg::LS_IDLE;
                    end else if (k == descent_pkg::MAX_SHIFT) begin
                        // no decrease found at any step length
                        ls_ok   <= 1'b0;
                        ls_done <= 1'b1;
                        state   <= descent_pkg::LS_IDLE;
                    end else begin
                        k          <= k + 4'd1;
                        step_start <= 1'b1;
                        state      <= descent_pkg::LS_STEP;
                    end
                end
                default: begin
                    state <= descent_pkg::LS_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/descent_ctrl.sv
module descent_ctrl (
    input  logic               clk,
    input  logic               rst_LBFGS,
    input  logic               start,
    input  descent_pkg::val_t  x_init [descent_pkg::N_ELEM],
    input  logic               eval_done,
    input  descent_pkg::obj_t  eval_f,
    input  descent_pkg::val_t  eval_grad [descent_pkg::N_ELEM],
    input  descent_pkg::val_t  trial_point [descent_pkg::N_ELEM],
    input  logic               ls_eval_req,
    input  logic               ls_done,
    input  logic               ls_ok,
    output logic               eval_start,
    output descent_pkg::val_t  eval_point [descent_pkg::N_ELEM],
    output logic               ls_start,
    output logic               ls_eval_done,
    output descent_pkg::val_t  cur_point [descent_pkg::N_ELEM],
    output descent_pkg::val_t  cur_grad [descent_pkg::N_ELEM],
    output descent_pkg::obj_t  f_now,
    output logic               busy,
    output logic               done,
    output logic               converged,
    output descent_pkg::val_t  x_result [descent_pkg::N_ELEM],
    output descent_pkg::obj_t  f_result,
    output descent_pkg::iter_t iter_count
);

    descent_pkg::phase_t phase;
    logic                init_start;
    descent_pkg::obj_t   delta;
    descent_pkg::obj_t   delta_mag;

    ////////////////////////////////////////////////////////////
    // evaluator sharing
    ////////////////////////////////////////////////////////////

    // phases never overlap, so a plain OR is enough
    assign eval_start   = init_start || ls_eval_req;
    assign ls_eval_done = eval_done && (phase == descent_pkg::PH_SEARCH);

    always_comb begin
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            eval_point[i] = (phase == descent_pkg::PH_SEARCH) ? trial_point[i] : cur_point[i];
        end
    end

    // objective change of the accepted step
    always_comb begin
        delta     = f_now - eval_f;
        delta_mag = delta[descent_pkg::OBJ_W-1] ? -delta : delta;
    end

    ////////////////////////////////////////////////////////////
    // phase FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            phase      <= descent_pkg::PH_IDLE;
            init_start <= 1'b0;
            ls_start   <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            converged  <= 1'b0;
            iter_count <= '0;
        end else begin
            init_start <= 1'b0;
            ls_start   <= 1'b0;
            done       <= 1'b0;
            case (phase)
                descent_pkg::PH_IDLE: begin
                    if (start) begin
                        cur_point  <= x_init;
                        init_start <= 1'b1;
                        busy       <= 1'b1;
                        converged  <= 1'b0;
                        iter_count <= '0;
                        phase      <= descent_pkg::PH_INIT_EVAL;
                    end
                end
                descent_pkg::PH_INIT_EVAL: begin
                    if (eval_done) begin
                        cur_grad <= eval_grad;
                        f_now    <= eval_f;
                        ls_start <= 1'b1;
                        phase    <= descent_pkg::PH_SEARCH;
                    end
                end
                descent_pkg::PH_SEARCH: begin
                    if (ls_done) begin
                        // failed search keeps the current point
                        phase <= ls_ok ? descent_pkg::PH_JUDGE : descent_pkg::PH_DONE;
                    end
                end
                descent_pkg::PH_JUDGE: begin
                    // accepted trial is still on the evaluator outputs
                    iter_count <= iter_count + 5'd1;
                    cur_point  <= trial_point;
                    cur_grad   <= eval_grad;
                    f_now      <= eval_f;
                    if (delta_mag <= descent_pkg::EPSILON) begin
                        converged <= 1'b1;
                        phase     <= descent_pkg::PH_DONE;
                    end else if (iter_count == descent_pkg::MAX_ITER - 1) begin
                        phase <= descent_pkg::PH_DONE;
                    end else begin
                        ls_start <= 1'b1;
                        phase    <= descent_pkg::PH_SEARCH;
                    end
                end
                descent_pkg::PH_DONE: begin
                    x_result <= cur_point;
                    f_result <= f_now;
                    done     <= 1'b1;
                    busy     <= 1'b0;
                    phase    <= descent_pkg::PH_IDLE;
                end
                default: begin
                    phase <= descent_pkg::PH_IDLE;
                end
            endcase
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        done |=> !done);

    a_phase_legal: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        phase inside {descent_pkg::PH_IDLE, descent_pkg::PH_INIT_EVAL,
                      descent_pkg::PH_SEARCH, descent_pkg::PH_JUDGE,
                      descent_pkg::PH_DONE});

endmodule

//--- rtl/descent_top.sv
module descent_top (
    input  logic               clk,
    input  logic               rst_LBFGS,
    input  logic               param_we,
    input  descent_pkg::addr_t param_addr,
    input  descent_pkg::val_t  param_weight,
    input  descent_pkg::val_t  param_mean,
    input  descent_pkg::val_t  x_init [descent_pkg::N_ELEM],
    input  logic               start,
    output logic               busy,
    output logic               done,
    output logic               converged,
    output descent_pkg::val_t  x_result [descent_pkg::N_ELEM],
    output descent_pkg::obj_t  f_result,
    output descent_pkg::iter_t iter_count
);

    // evaluator
    logic                eval_start;
    logic                eval_done;
    descent_pkg::obj_t   eval_f;
    descent_pkg::val_t   eval_point [descent_pkg::N_ELEM];
    descent_pkg::val_t   eval_grad  [descent_pkg::N_ELEM];

    // line search
    logic                ls_start;
    logic                ls_eval_req;
    logic                ls_eval_done;
    logic                ls_done;
    logic                ls_ok;
    descent_pkg::obj_t   f_now;
    descent_pkg::val_t   cur_point [descent_pkg::N_ELEM];
    descent_pkg::val_t   cur_grad  [descent_pkg::N_ELEM];

    // trial point
    logic                step_start;
    logic                step_done;
    descent_pkg::shift_t step_shift;
    descent_pkg::val_t   trial_point [descent_pkg::N_ELEM];

    descent_ctrl u_ctrl (
        .clk          (clk),
        .rst_LBFGS    (rst_LBFGS),
        .start        (start),
        .x_init       (x_init),
        .eval_done    (eval_done),
        .eval_f       (eval_f),
        .eval_grad    (eval_grad),
        .trial_point  (trial_point),
        .ls_eval_req  (ls_eval_req),
        .ls_done      (ls_done),
        .ls_ok        (ls_ok),
        .eval_start   (eval_start),
        .eval_point   (eval_point),
        .ls_start     (ls_start),
        .ls_eval_done (ls_eval_done),
        .cur_point    (cur_point),
        .cur_grad     (cur_grad),
        .f_now        (f_now),
        .busy         (busy),
        .done         (done),
        .converged    (converged),
        .x_result     (x_result),
        .f_result     (f_result),
        .iter_count   (iter_count)
    );

    objective_eval u_eval (
        .clk          (clk),
        .rst_LBFGS    (rst_LBFGS),
        .param_we     (param_we),
        .param_addr   (param_addr),
        .param_weight (param_weight),
        .param_mean   (param_mean),
        .eval_start   (eval_start),
        .eval_point   (eval_point),
        .eval_done    (eval_done),
        .eval_f       (eval_f),
        .eval_grad    (eval_grad)
    );

    line_search u_search (
        .clk          (clk),
        .rst_LBFGS    (rst_LBFGS),
        .ls_start     (ls_start),
        .f_now        (f_now),
        .eval_f       (eval_f),
        .ls_eval_done (ls_eval_done),
        .step_done    (step_done),
        .step_start   (step_start),
        .step_shift   (step_shift),
        .ls_eval_req  (ls_eval_req),
        .ls_done      (ls_done),
        .ls_ok        (ls_ok)
    );

    point_update u_step (
        .clk          (clk),
        .rst_LBFGS    (rst_LBFGS),
        .step_start   (step_start),
        .step_shift   (step_shift),
        .base_point   (cur_point),
        .grad         (cur_grad),
        .step_done    (step_done),
        .trial_point  (trial_point)
    );

endmodule

//--- tb/tb_descent_model.svh
`ifndef TB_DESCENT_MODEL_SVH
`define TB_DESCENT_MODEL_SVH

////////////////////////////////////////////////////////////
// fixed-point objective and gradient
////////////////////////////////////////////////////////////

// f = sum of w*d*d, g = 2*w*d, with d = x - mean
function automatic void objective_model(
    input  descent_pkg::val_t x [descent_pkg::N_ELEM],
    input  descent_pkg::val_t w [descent_pkg::N_ELEM],
    input  descent_pkg::val_t m [descent_pkg::N_ELEM],
    output descent_pkg::obj_t f,
    output descent_pkg::val_t g [descent_pkg::N_ELEM]
);
    descent_pkg::val_t  d;
    logic signed [63:0] w_wide;
    logic signed [63:0] d_wide;
    logic signed [63:0] p;
    logic signed [95:0] p_ext;
    logic signed [95:0] d_ext;
    logic signed [95:0] sq;
    f = '0;
    for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
        d      = x[i] - m[i];
        w_wide = w[i];
        d_wide = d;
        p      = (w_wide * d_wide) >>> descent_pkg::FRAC_BITS;
        p_ext  = p;
        d_ext  = d;
        sq     = p_ext * d_ext;
        f      = f + descent_pkg::obj_t'(sq >>> descent_pkg::FRAC_BITS);
        g[i]   = descent_pkg::val_t'(p <<< 1);
    end
endfunction

////////////////////////////////////////////////////////////
// whole optimizer run
////////////////////////////////////////////////////////////

function automatic void descent_model(
    input  descent_pkg::val_t  x0 [descent_pkg::N_ELEM],
    input  descent_pkg::val_t  w  [descent_pkg::N_ELEM],
    input  descent_pkg::val_t  m  [descent_pkg::N_ELEM],
    output descent_pkg::val_t  xr [descent_pkg::N_ELEM],
    output descent_pkg::obj_t  fr,
    output logic               conv,
    output descent_pkg::iter_t iters
);
    descent_pkg::val_t x  [descent_pkg::N_ELEM];
    descent_pkg::val_t g  [descent_pkg::N_ELEM];
    descent_pkg::val_t xt [descent_pkg::N_ELEM];
    descent_pkg::val_t gt [descent_pkg::N_ELEM];
    descent_pkg::obj_t f;
    descent_pkg::obj_t ft;
    descent_pkg::obj_t change;
    logic              accepted;
    logic              running;
    int                k;
    x = x0;
    objective_model(x, w, m, f, g);
    conv    = 1'b0;
    iters   = '0;
    running = 1'b1;
    while (running) begin
        // first step 2**-k that lowers the objective at all
        accepted = 1'b0;
        for (k = 0; k <= descent_pkg::MAX_SHIFT && !accepted; k++) begin
            for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
                xt[i] = x[i] - (g[i] >>> k);
            end
            objective_model(xt, w, m, ft, gt);
            accepted = (ft < f);
        end
        if (!accepted) begin
            running = 1'b0;
        end else begin
            change = f - ft;
            if (change < 0) begin
                change = -change;
            end
            x     = xt;
            g     = gt;
            f     = ft;
            iters = iters + 1'b1;
            if (change <= descent_pkg::EPSILON) begin
                conv    = 1'b1;
                running = 1'b0;
            end else if (iters == descent_pkg::MAX_ITER) begin
                running = 1'b0;
            end
        end
    end
    xr = x;
    fr = f;
endfunction

`endif

//--- tb/tb_descent_top.sv
module tb_descent_top;

    localparam int NUM_RUNS    = 16;
    localparam int CYCLE_LIMIT = NUM_RUNS * descent_pkg::MAX_ITER * (descent_pkg::MAX_SHIFT + 1)
                                 * (2 * descent_pkg::N_ELEM + 6) + 200;

    logic               clk;
    logic               rst_LBFGS;
    logic               param_we;
    descent_pkg::addr_t param_addr;
    descent_pkg::val_t  param_weight;
    descent_pkg::val_t  param_mean;
    descent_pkg::val_t  x_init [descent_pkg::N_ELEM];
    logic               start;
    logic               busy;
    logic               done;
    logic               converged;
    descent_pkg::val_t  x_result [descent_pkg::N_ELEM];
    descent_pkg::obj_t  f_result;
    descent_pkg::iter_t iter_count;

    // expected outcome of the run in flight
    descent_pkg::val_t  w_cur [descent_pkg::N_ELEM];
    descent_pkg::val_t  m_cur [descent_pkg::N_ELEM];
    descent_pkg::val_t  exp_x [descent_pkg::N_ELEM];
    descent_pkg::obj_t  exp_f;
    logic               exp_conv;
    descent_pkg::iter_t exp_iter;
    logic               run_pending;
    int                 runs_done;
    int                 checks;
    int                 errors;
    int                 cycles;

    `include "tb_descent_model.svh"

    descent_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_vec(input string what, input descent_pkg::val_t got [descent_pkg::N_ELEM],
                             input descent_pkg::val_t exp [descent_pkg::N_ELEM]);
        checks++;
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            if (got[i] !== exp[i]) begin
                $display("** Error at %0t: %s[%0d] is %0d, expected %0d",
                         $time, what, i, got[i], exp[i]);
                errors++;
            end
        end
    endtask

    task automatic check_obj(input string what, input descent_pkg::obj_t got,
                             input descent_pkg::obj_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_iter(input string what, input descent_pkg::iter_t got,
                              input descent_pkg::iter_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // result comparison on every done pulse
    initial begin
        forever begin
            @(negedge clk);
            if (done) begin
                if (!run_pending) begin
                    $display("done pulse at %0t while no run was expected to finish", $time);
                    errors++;
                end
                check_vec("x_result", x_result, exp_x);
                check_obj("f_result", f_result, exp_f);
                check_iter("iter_count", iter_count, exp_iter);
                check_bit("converged", converged, exp_conv);
                run_pending = 1'b0;
                runs_done++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic int random_in(input int lo, input int span);
        return lo + int'($urandom % span);
    endfunction

    task automatic load_params(input descent_pkg::val_t w [descent_pkg::N_ELEM],
                               input descent_pkg::val_t m [descent_pkg::N_ELEM]);
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            @(posedge clk);
            #1;
            param_we     = 1'b1;
            param_addr   = descent_pkg::addr_t'(i);
            param_weight = w[i];
            param_mean   = m[i];
            w_cur[i]     = w[i];
            m_cur[i]     = m[i];
        end
        @(posedge clk);
        #1;
        param_we = 1'b0;
    endtask

    task automatic pulse_start(input descent_pkg::val_t x0 [descent_pkg::N_ELEM]);
        @(posedge clk);
        #1;
        x_init = x0;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic run_problem(input descent_pkg::val_t x0 [descent_pkg::N_ELEM]);
        int target;
        descent_model(x0, w_cur, m_cur, exp_x, exp_f, exp_conv, exp_iter);
        target      = runs_done + 1;
        run_pending = 1'b1;
        pulse_start(x0);
        wait (runs_done == target);
    endtask

    // weights around one base value, means and starts within +-32
    task automatic make_random_problem(output descent_pkg::val_t w  [descent_pkg::N_ELEM],
                                       output descent_pkg::val_t m  [descent_pkg::N_ELEM],
                                       output descent_pkg::val_t x0 [descent_pkg::N_ELEM]);
        int base;
        int wi;
        base = random_in(16384, 245760);
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            wi = base - base / 32 + random_in(0, base / 16);
            if (wi > 262143) begin
                wi = 262143;
            end
            if (wi < 16384) begin
                wi = 16384;
            end
            w[i]  = wi;
            m[i]  = random_in(-2097152, 4194304);
            x0[i] = random_in(-2097152, 4194304);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %s: %0d error(s)", name, errors - err_start);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        descent_pkg::val_t  w  [descent_pkg::N_ELEM];
        descent_pkg::val_t  m  [descent_pkg::N_ELEM];
        descent_pkg::val_t  xa [descent_pkg::N_ELEM];
        descent_pkg::val_t  xb [descent_pkg::N_ELEM];
        descent_pkg::val_t  x_tmp [descent_pkg::N_ELEM];
        descent_pkg::obj_t  f_tmp;
        descent_pkg::iter_t it_tmp;
        logic               conv_tmp;
        logic               found;
        int                 err_start;
        int                 run_target;

        void'($urandom(32'he414));
        rst_LBFGS    = 1'b0;
        param_we     = 1'b0;
        param_addr   = '0;
        param_weight = '0;
        param_mean   = '0;
        start        = 1'b0;
        run_pending  = 1'b0;
        runs_done    = 0;
        checks       = 0;
        errors       = 0;
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            x_init[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_LBFGS = 1'b1;

        // unit weights, zero means
        err_start = errors;
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            w[i]  = 32'sd65536;
            m[i]  = '0;
            xa[i] = descent_pkg::val_t'((i + 1) * 16384);
        end
        load_params(w, m);
        run_problem(xa);
        report_test("1 parameter load and simple case", err_start);

        // only problems that the reference expects to converge
        err_start = errors;
        for (int p = 0; p < 10; p++) begin
            found = 1'b0;
            for (int t = 0; t < 200 && !found; t++) begin
                make_random_problem(w, m, xa);
                descent_model(xa, w, m, x_tmp, f_tmp, conv_tmp, it_tmp);
                found = conv_tmp;
            end
            if (found) begin
                load_params(w, m);
                run_problem(xa);
            end else begin
                $display("no converging random problem was found for problem %0d", p);
                errors++;
            end
        end
        report_test("2 random problems", err_start);

        // zero gradient, so no step can lower the objective
        err_start = errors;
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            w[i] = descent_pkg::val_t'(32768 + 16384 * i);
            m[i] = descent_pkg::val_t'((i - 4) * 98304);
        end
        load_params(w, m);
        run_problem(m);
        check_bit("converged at minimum", converged, 1'b0);
        check_iter("iter_count at minimum", iter_count, '0);
        check_vec("x_result at minimum", x_result, m);
        report_test("3 start at the minimum", err_start);

        // slow progress runs out of iterations
        err_start = errors;
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            w[i]  = 32'sd256;
            m[i]  = '0;
            xa[i] = descent_pkg::val_t'((i % 2 == 0 ? 1 : -1) * (100 + 10 * i) * 65536);
        end
        load_params(w, m);
        run_problem(xa);
        check_bit("converged at limit", converged, 1'b0);
        check_iter("iter_count at limit", iter_count, descent_pkg::iter_t'(descent_pkg::MAX_ITER));
        report_test("4 iteration limit", err_start);

        // busy, ignored second start, reset in mid-run
        err_start = errors;
        for (int i = 0; i < descent_pkg::N_ELEM; i++) begin
            w[i]  = 32'sd24576;
            m[i]  = descent_pkg::val_t'((i - 3) * 65536);
            xa[i] = descent_pkg::val_t'((7 - i) * 131072);
            xb[i] = descent_pkg::val_t'((i - 5) * 196608);
        end
        load_params(w, m);
        descent_model(xa, w_cur, m_cur, exp_x, exp_f, exp_conv, exp_iter);
        run_target  = runs_done + 1;
        run_pending = 1'b1;
        pulse_start(xa);
        check_bit("busy after start", busy, 1'b1);
        repeat (3) @(posedge clk);
        pulse_start(xb);
        wait (runs_done == run_target);
        // aborted run starts elsewhere than the run after reset
        pulse_start(xa);
        repeat (10) @(posedge clk);
        #1;
        check_bit("busy before reset", busy, 1'b1);
        rst_LBFGS = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        check_bit("busy in reset", busy, 1'b0);
        check_bit("done in reset", done, 1'b0);
        rst_LBFGS = 1'b1;
        run_problem(xb);
        report_test("5 protocol", err_start);

        $display("runs %0d, checks %0d, errors %0d", runs_done, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+tb
rtl/descent_pkg.sv
rtl/objective_eval.sv
rtl/point_update.sv
rtl/line_search.sv
rtl/descent_ctrl.sv
rtl/descent_top.sv
tb/tb_descent_top.sv
